// ==== tb.f ====
+incdir+verif
hdl/mem_msg_pkg.sv
hdl/tile_map_pkg.sv
hdl/cfg_slice.sv
hdl/clint_slice.sv
hdl/mem_xbar.sv
hdl/device_tile.sv
verif/device_tile_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the device tile testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module device_tile_tb -o device_tile_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/device_tile_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// ==== verif/device_tile_vectors.svh ====
// columns: source, opcode, address, write data, expected read data,
// data check enable, output to watch afterwards, expected value of that output

localparam logic [2:0] w_none = 3'd0;
localparam logic [2:0] w_freeze = 3'd1;
localparam logic [2:0] w_sw_irq = 3'd2;
localparam logic [2:0] w_timer_irq = 3'd3;
localparam logic [2:0] w_npc = 3'd4;
// read data must exceed the previous unchecked read
localparam logic [2:0] w_grows = 3'd5;

typedef struct packed {
  src_id_t    src;
  mem_op_e    op;
  addr_t      addr;
  data_t      wdata;
  data_t      rdata;
  logic       chk;
  logic [2:0] watch;
  data_t      wval;
} vec_t;

localparam int num_vec_c = 25;

vec_t vec_table [num_vec_c] = '{
  // reset values
  '{1'b0, op_read,  24'h20000c, 32'h0,        32'h5,        1'b1, w_freeze,    32'h1},
  '{1'b1, op_read,  24'h200004, 32'h0,        32'h1,        1'b1, w_npc,       32'h80000000},
  '{1'b0, op_read,  24'h200008, 32'h0,        32'h80000000, 1'b1, w_sw_irq,    32'h0},
  '{1'b1, op_read,  24'h304000, 32'h0,        32'hffffffff, 1'b1, w_timer_irq, 32'h0},
  // configuration writes
  '{1'b0, op_write, 24'h200004, 32'h0,        32'h0,        1'b1, w_freeze,    32'h0},
  '{1'b0, op_read,  24'h200004, 32'h0,        32'h0,        1'b1, w_none,      32'h0},
  '{1'b1, op_write, 24'h200008, 32'h1000,     32'h0,        1'b1, w_npc,       32'h1000},
  '{1'b0, op_read,  24'h200008, 32'h0,        32'h1000,     1'b1, w_none,      32'h0},
  '{1'b1, op_write, 24'h20000c, 32'h77,       32'h0,        1'b1, w_none,      32'h0},
  '{1'b0, op_read,  24'h20000c, 32'h0,        32'h5,        1'b1, w_none,      32'h0},
  // clint
  '{1'b0, op_write, 24'h300000, 32'h1,        32'h0,        1'b1, w_sw_irq,    32'h1},
  '{1'b1, op_read,  24'h300000, 32'h0,        32'h1,        1'b1, w_none,      32'h0},
  '{1'b0, op_write, 24'h300000, 32'h0,        32'h0,        1'b1, w_sw_irq,    32'h0},
  '{1'b1, op_read,  24'h30bff8, 32'h0,        32'h0,        1'b0, w_grows,     32'h0},
  '{1'b0, op_read,  24'h30bff8, 32'h0,        32'h0,        1'b0, w_grows,     32'h0},
  '{1'b0, op_write, 24'h30bff8, 32'h1000,     32'h0,        1'b1, w_none,      32'h0},
  '{1'b1, op_write, 24'h304000, 32'h800,      32'h0,        1'b1, w_timer_irq, 32'h1},
  '{1'b0, op_read,  24'h304000, 32'h0,        32'h800,      1'b1, w_none,      32'h0},
  '{1'b1, op_write, 24'h304000, 32'hffffffff, 32'h0,        1'b1, w_timer_irq, 32'h0},
  // loopback and unknown offsets
  '{1'b0, op_read,  24'h000010, 32'h0,        32'h0,        1'b1, w_none,      32'h0},
  '{1'b1, op_write, 24'h500010, 32'hdeadbeef, 32'h0,        1'b1, w_none,      32'h0},
  '{1'b0, op_read,  24'h500010, 32'h0,        32'h0,        1'b1, w_none,      32'h0},
  '{1'b1, op_read,  24'hf0bff8, 32'h0,        32'h0,        1'b1, w_none,      32'h0},
  '{1'b0, op_read,  24'h400004, 32'h0,        32'h0,        1'b1, w_none,      32'h0},
  '{1'b1, op_read,  24'h200010, 32'h0,        32'h0,        1'b1, w_none,      32'h0}
};

// ==== verif/device_tile_tb.sv ====
`timescale 1ns/1ns

module device_tile_tb;

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  localparam int clk_period_c = 40;
  localparam data_t core_id_c = 32'd5;
  localparam data_t boot_npc_c = 32'h8000_0000;
  localparam int rand_pairs_c = 40;
  localparam int seed_c = 32'h4b34;

  `include "device_tile_vectors.svh"

  localparam int max_cycles_c = 4 * num_vec_c + 2 * rand_pairs_c + 50;

  // one outstanding reply in issue order
  typedef struct packed {
    src_id_t src;
    data_t   data;
    logic    chk;
    int      due;
  } exp_t;

  logic                     clk_i;
  logic                     arst_n_i;
  logic [num_src_gp-1:0]    req_v_i;
  mem_op_e [num_src_gp-1:0] req_op_i;
  addr_t [num_src_gp-1:0]   req_addr_i;
  data_t [num_src_gp-1:0]   req_data_i;
  logic [num_src_gp-1:0]    req_ready_o;
  logic [num_src_gp-1:0]    rsp_v_o;
  data_t [num_src_gp-1:0]   rsp_data_o;
  logic                     freeze_o;
  data_t                    boot_npc_o;
  logic                     timer_irq_o;
  logic                     software_irq_o;

  int    cycle;
  int    seed;
  exp_t  exp_q[$];
  data_t last_rd;
  data_t prev_rd;

  // register model of the configuration slice
  logic  m_freeze;
  data_t m_npc;

  device_tile
    #(
      .core_id_p  (core_id_c),
      .boot_npc_p (boot_npc_c)
    )
  dut
    (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .req_v_i        (req_v_i),
      .req_op_i       (req_op_i),
      .req_addr_i     (req_addr_i),
      .req_data_i     (req_data_i),
      .req_ready_o    (req_ready_o),
      .rsp_v_o        (rsp_v_o),
      .rsp_data_o     (rsp_data_o),
      .freeze_o       (freeze_o),
      .boot_npc_o     (boot_npc_o),
      .timer_irq_o    (timer_irq_o),
      .software_irq_o (software_irq_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever
      #(clk_period_c / 2) clk_i = ~clk_i;
  end

  initial
  begin
    cycle = 0;
    repeat (max_cycles_c)
    begin
      @(posedge clk_i);
      cycle = cycle + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", max_cycles_c);
    $display("Verification failed");
    $fatal(1);
  end

  task automatic report_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp)
      report_error($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
  endtask

  task automatic check_flag(input string what, input bit got, input bit exp);
    if (got !== exp)
      report_error($sformatf("%s is %0b, expected %0b", what, got, exp));
  endtask

  task automatic check_rsp_port(input src_id_t got, input src_id_t exp);
    if (got !== exp)
      report_error($sformatf("reply on port %0d, issued by source %0d", got, exp));
  endtask

  // replies are sampled on the falling edge
  task automatic check_responses();
    exp_t    e;
    src_id_t port;
    if (rsp_v_o == '0)
    begin
      if (exp_q.size() != 0 && exp_q[0].due <= cycle)
        report_error($sformatf("no reply for source %0d in cycle %0d", exp_q[0].src, cycle));
    end
    else
    begin
      if ($countones(rsp_v_o) != 1)
        report_error("replies on both source ports in one cycle");
      if (exp_q.size() == 0)
        report_error("reply with no request outstanding");
      e = exp_q.pop_front();
      port = src_id_t'(rsp_v_o[1]);
      check_rsp_port(port, e.src);
      check_flag("reply two cycles after acceptance", e.due == cycle, 1'b1);
      last_rd = rsp_data_o[port];
      if (e.chk)
        check_data("read data", last_rd, e.data);
    end
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    check_responses();
  endtask

  task automatic model_access(input mem_op_e op, input addr_t addr, input data_t wdata,
                              output data_t rd);
    logic [3:0] code;
    reg_off_t   off;
    code = addr[23:20];
    off = addr[15:0];
    rd = '0;
    // clint replies come from the table
    // loopback and writes answer zero
    if (code == 4'h2)
    begin
      if (op == op_write)
      begin
        if (off == cfg_freeze_gp)
          m_freeze = wdata[0];
        else if (off == cfg_npc_gp)
          m_npc = wdata;
      end
      else if (off == cfg_freeze_gp)
        rd = {31'b0, m_freeze};
      else if (off == cfg_npc_gp)
        rd = m_npc;
      else if (off == cfg_core_id_gp)
        rd = core_id_c;
    end
  endtask

  // holds every valid source until ready, then books its reply
  task automatic issue_pending(input logic tbl_mode, input data_t tbl_data, input logic tbl_chk);
    logic [num_src_gp-1:0] granted;
    data_t                 pred;
    exp_t                  e;
    while (req_v_i != '0)
    begin
      #(clk_period_c / 4);
      granted = req_v_i & req_ready_o;
      if (granted == '0)
        report_error("request stalled with ready low");
      if (&req_v_i)
        check_flag("single grant when both sources ask", $countones(granted) == 1, 1'b1);
      for (int s = 0; s < num_src_gp; s++)
      begin
        if (granted[s])
        begin
          model_access(req_op_i[s], req_addr_i[s], req_data_i[s], pred);
          e.src = src_id_t'(s);
          e.data = tbl_mode ? tbl_data : pred;
          e.chk = tbl_mode ? tbl_chk : 1'b1;
          e.due = cycle + 2;
          exp_q.push_back(e);
        end
      end
      next_cycle();
      req_v_i = req_v_i & ~granted;
    end
  endtask

  function automatic logic watched_flag(input logic [2:0] watch);
    case (watch)
      w_freeze: return freeze_o;
      w_sw_irq: return software_irq_o;
      default:  return timer_irq_o;
    endcase
  endfunction

  function automatic string flag_name(input logic [2:0] watch);
    case (watch)
      w_freeze: return "freeze_o";
      w_sw_irq: return "software_irq_o";
      default:  return "timer_irq_o";
    endcase
  endfunction

  task automatic check_watch(input logic [2:0] watch, input data_t wval);
    int waited;
    case (watch)
      w_npc:
        check_data("boot_npc_o", boot_npc_o, wval);
      w_grows:
      begin
        check_flag("mtime advances between reads", last_rd > prev_rd, 1'b1);
        prev_rd = last_rd;
      end
      w_freeze, w_sw_irq, w_timer_irq:
      begin
        // timer interrupt trails the mtimecmp write by a cycle
        waited = 0;
        while (watched_flag(watch) != wval[0] && waited < 3)
        begin
          next_cycle();
          waited = waited + 1;
        end
        check_flag(flag_name(watch), watched_flag(watch), wval[0]);
      end
      default:
        ;
    endcase
  endtask

  task automatic random_request(input int s);
    logic [31:0] rnd;
    logic [3:0]  code;
    reg_off_t    off;
    rnd = $random(seed);
    if (rnd[31])
    begin
      code = 4'h2;
      case (rnd[25:24])
        2'd0:    off = cfg_freeze_gp;
        2'd1:    off = cfg_npc_gp;
        2'd2:    off = cfg_core_id_gp;
        default: off = 16'h0010;
      endcase
    end
    else
    begin
      // any code but cfg and clint lands on the loopback
      code = rnd[23:20];
      if (code == 4'h2 || code == 4'h3)
        code = code ^ 4'h8;
      off = rnd[15:0];
    end
    req_op_i[s] = rnd[30] ? op_write : op_read;
    req_addr_i[s] = {code, rnd[19:16], off};
    req_data_i[s] = $random(seed);
    req_v_i[s] = 1'b1;
  endtask

  initial
  begin
    seed = seed_c;
    last_rd = '0;
    prev_rd = '0;
    m_freeze = 1'b1;
    m_npc = boot_npc_c;
    arst_n_i = 1'b0;
    req_v_i = '0;
    for (int s = 0; s < num_src_gp; s++)
    begin
      req_op_i[s] = op_read;
      req_addr_i[s] = '0;
      req_data_i[s] = '0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    next_cycle();
    check_flag("req_ready_o after reset", &req_ready_o, 1'b1);

    // directed entries from one source at a time
    for (int i = 0; i < num_vec_c; i++)
    begin
      req_op_i[vec_table[i].src] = vec_table[i].op;
      req_addr_i[vec_table[i].src] = vec_table[i].addr;
      req_data_i[vec_table[i].src] = vec_table[i].wdata;
      req_v_i[vec_table[i].src] = 1'b1;
      issue_pending(1'b1, vec_table[i].rdata, vec_table[i].chk);
      while (exp_q.size() != 0)
        next_cycle();
      check_watch(vec_table[i].watch, vec_table[i].wval);
    end

    // both sources at once with replies from the model
    for (int i = 0; i < rand_pairs_c; i++)
    begin
      for (int s = 0; s < num_src_gp; s++)
        random_request(s);
      issue_pending(1'b0, '0, 1'b0);
    end
    while (exp_q.size() != 0)
      next_cycle();
    check_flag("freeze_o", freeze_o, m_freeze);
    check_data("boot_npc_o", boot_npc_o, m_npc);

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== hdl/device_tile.sv ====
`timescale 1ns/1ns

module device_tile
  #(
    parameter mem_msg_pkg::data_t core_id_p = 32'd0,
    parameter mem_msg_pkg::data_t boot_npc_p = 32'h8000_0000
  )
  (
    input  logic                                                  clk_i,
    input  logic                                                  arst_n_i,

    input  logic [mem_msg_pkg::num_src_gp-1:0]                    req_v_i,
    input  mem_msg_pkg::mem_op_e [mem_msg_pkg::num_src_gp-1:0]    req_op_i,
    input  mem_msg_pkg::addr_t [mem_msg_pkg::num_src_gp-1:0]      req_addr_i,
    input  mem_msg_pkg::data_t [mem_msg_pkg::num_src_gp-1:0]      req_data_i,
    output logic [mem_msg_pkg::num_src_gp-1:0]                    req_ready_o,

    output logic [mem_msg_pkg::num_src_gp-1:0]                    rsp_v_o,
    output mem_msg_pkg::data_t [mem_msg_pkg::num_src_gp-1:0]      rsp_data_o,

    output logic                                                  freeze_o,
    output mem_msg_pkg::data_t                                    boot_npc_o,
    output logic                                                  timer_irq_o,
    output logic                                                  software_irq_o
  );

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  // crossbar to device slices
  logic     cfg_v;
  logic     clint_v;
  mem_op_e  dev_op;
  reg_off_t dev_off;
  data_t    dev_data;
  src_id_t  dev_src;

  // slice replies back into the crossbar
  logic     cfg_rsp_v;
  data_t    cfg_rsp_data;
  src_id_t  cfg_rsp_src;
  logic     clint_rsp_v;
  data_t    clint_rsp_data;
  src_id_t  clint_rsp_src;

  mem_xbar xbar
    (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .req_v_i          (req_v_i),
      .req_op_i         (req_op_i),
      .req_addr_i       (req_addr_i),
      .req_data_i       (req_data_i),
      .req_ready_o      (req_ready_o),
      .rsp_v_o          (rsp_v_o),
      .rsp_data_o       (rsp_data_o),
      .cfg_v_o          (cfg_v),
      .clint_v_o        (clint_v),
      .dev_op_o         (dev_op),
      .dev_off_o        (dev_off),
      .dev_data_o       (dev_data),
      .dev_src_o        (dev_src),
      .cfg_rsp_v_i      (cfg_rsp_v),
      .cfg_rsp_data_i   (cfg_rsp_data),
      .cfg_rsp_src_i    (cfg_rsp_src),
      .clint_rsp_v_i    (clint_rsp_v),
      .clint_rsp_data_i (clint_rsp_data),
      .clint_rsp_src_i  (clint_rsp_src)
    );

  cfg_slice
    #(
      .core_id_p  (core_id_p),
      .boot_npc_p (boot_npc_p)
    )
  cfgs
    (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .v_i        (cfg_v),
      .op_i       (dev_op),
      .off_i      (dev_off),
      .data_i     (dev_data),
      .src_i      (dev_src),
      .rsp_v_o    (cfg_rsp_v),
      .rsp_data_o (cfg_rsp_data),
      .rsp_src_o  (cfg_rsp_src),
      .freeze_o   (freeze_o),
      .boot_npc_o (boot_npc_o)
    );

  clint_slice clint
    (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .v_i            (clint_v),
      .op_i           (dev_op),
      .off_i          (dev_off),
      .data_i         (dev_data),
      .src_i          (dev_src),
      .rsp_v_o        (clint_rsp_v),
      .rsp_data_o     (clint_rsp_data),
      .rsp_src_o      (clint_rsp_src),
      .timer_irq_o    (timer_irq_o),
      .software_irq_o (software_irq_o)
    );

endmodule

// ==== hdl/mem_xbar.sv ====
`timescale 1ns/1ns

module mem_xbar
  (
    input  logic                                                  clk_i,
    input  logic                                                  arst_n_i,

    input  logic [mem_msg_pkg::num_src_gp-1:0]                    req_v_i,
    input  mem_msg_pkg::mem_op_e [mem_msg_pkg::num_src_gp-1:0]    req_op_i,
    input  mem_msg_pkg::addr_t [mem_msg_pkg::num_src_gp-1:0]      req_addr_i,
    input  mem_msg_pkg::data_t [mem_msg_pkg::num_src_gp-1:0]      req_data_i,
    output logic [mem_msg_pkg::num_src_gp-1:0]                    req_ready_o,

    output logic [mem_msg_pkg::num_src_gp-1:0]                    rsp_v_o,
    output mem_msg_pkg::data_t [mem_msg_pkg::num_src_gp-1:0]      rsp_data_o,

    output logic                                                  cfg_v_o,
    output logic                                                  clint_v_o,
    output mem_msg_pkg::mem_op_e                                  dev_op_o,
    output tile_map_pkg::reg_off_t                                dev_off_o,
    output mem_msg_pkg::data_t                                    dev_data_o,
    output mem_msg_pkg::src_id_t                                  dev_src_o,

    input  logic                                                  cfg_rsp_v_i,
    input  mem_msg_pkg::data_t                                    cfg_rsp_data_i,
    input  mem_msg_pkg::src_id_t                                  cfg_rsp_src_i,
    input  logic                                                  clint_rsp_v_i,
    input  mem_msg_pkg::data_t                                    clint_rsp_data_i,
    input  mem_msg_pkg::src_id_t                                  clint_rsp_src_i
  );

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  logic [num_src_gp-1:0] grant;
  logic                  any_grant;
  logic                  contend;
  src_id_t               sel_src;
  src_id_t               rr_ptr_r;
  dev_code_t             sel_code;
  dev_e                  sel_dev;

  // request stage registers
  logic                  cfg_v_r;
  logic                  clint_v_r;
  logic                  lb_v_r;
  mem_op_e               op_r;
  reg_off_t              off_r;
  data_t                 data_r;
  src_id_t               src_r;

  // loopback answer register
  logic                  lb_rsp_v_r;
  src_id_t               lb_rsp_src_r;

  // merged response
  logic                  rsp_v;
  data_t                 rsp_data;
  src_id_t               rsp_src;

  // two sources only: on a conflict the pointer decides, a lone source always goes
  assign contend = &req_v_i;

  always_comb
  begin
    for (int i = 0; i < num_src_gp; i++)
    begin
      req_ready_o[i] = !contend || (rr_ptr_r == src_id_t'(i));
      grant[i] = req_v_i[i] && req_ready_o[i];
    end
  end

  assign any_grant = |grant;

  always_comb
  begin
    sel_src = '0;
    for (int i = 0; i < num_src_gp; i++)
    begin
      if (grant[i])
        sel_src = src_id_t'(i);
    end
  end

  // address decode of the granted request
  assign sel_code = req_addr_i[sel_src][dev_code_lsb_gp +: dev_code_width_gp];

  always_comb
  begin
    if (sel_code == dev_code_t'(dev_cfg))
      sel_dev = dev_cfg;
    else if (sel_code == dev_code_t'(dev_clint))
      sel_dev = dev_clint;
    else
      sel_dev = dev_loopback;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rr_ptr_r   <= '0;
      cfg_v_r    <= 1'b0;
      clint_v_r  <= 1'b0;
      lb_v_r     <= 1'b0;
      lb_rsp_v_r <= 1'b0;
    end
    else
    begin
      // loser of this cycle gets priority next time
      if (any_grant)
        rr_ptr_r <= sel_src + 1'b1;
      cfg_v_r    <= any_grant && (sel_dev == dev_cfg);
      clint_v_r  <= any_grant && (sel_dev == dev_clint);
      lb_v_r     <= any_grant && (sel_dev == dev_loopback);
      lb_rsp_v_r <= lb_v_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (any_grant)
    begin
      op_r   <= req_op_i[sel_src];
      off_r  <= reg_off_t'(req_addr_i[sel_src][reg_off_lsb_gp +: reg_off_width_gp]);
      data_r <= req_data_i[sel_src];
      src_r  <= sel_src;
    end
    lb_rsp_src_r <= src_r;
  end

  assign cfg_v_o    = cfg_v_r;
  assign clint_v_o  = clint_v_r;
  assign dev_op_o   = op_r;
  assign dev_off_o  = off_r;
  assign dev_data_o = data_r;
  assign dev_src_o  = src_r;

  // response merge, loopback always answers zero
  // accept at edge n, device strobe after n, reply after n+1, sampled at edge n+2
  always_comb
  begin
    rsp_v    = cfg_rsp_v_i || clint_rsp_v_i || lb_rsp_v_r;
    rsp_data = '0;
    rsp_src  = lb_rsp_src_r;
    if (cfg_rsp_v_i)
    begin
      rsp_data = cfg_rsp_data_i;
      rsp_src  = cfg_rsp_src_i;
    end
    else if (clint_rsp_v_i)
    begin
      rsp_data = clint_rsp_data_i;
      rsp_src  = clint_rsp_src_i;
    end
  end

  always_comb
  begin
    for (int i = 0; i < num_src_gp; i++)
    begin
      rsp_v_o[i]    = rsp_v && (rsp_src == src_id_t'(i));
      rsp_data_o[i] = rsp_data;
    end
  end

  // fixed latency keeps replies in order, so two devices never answer together
  a_one_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({cfg_rsp_v_i, clint_rsp_v_i, lb_rsp_v_r}));

  // any valid request wins exactly one grant
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|req_v_i) |-> $onehot(grant));

endmodule

// ==== hdl/clint_slice.sv ====
`timescale 1ns/1ns

module clint_slice
  (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    input  logic                   v_i,
    input  mem_msg_pkg::mem_op_e   op_i,
    input  tile_map_pkg::reg_off_t off_i,
    input  mem_msg_pkg::data_t     data_i,
    input  mem_msg_pkg::src_id_t   src_i,

    output logic                   rsp_v_o,
    output mem_msg_pkg::data_t     rsp_data_o,
    output mem_msg_pkg::src_id_t   rsp_src_o,

    output logic                   timer_irq_o,
    output logic                   software_irq_o
  );

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  data_t   mtime_r;
  data_t   mtimecmp_r;
  logic    msip_r;
  logic    timer_irq_r;
  data_t   rd_data;
  logic    wr;

  logic    rsp_v_r;
  data_t   rsp_data_r;
  src_id_t rsp_src_r;

  assign wr = v_i && (op_i == op_write);

  always_comb
  begin
    case (off_i)
      clint_msip_gp:     rd_data = data_t'(msip_r);
      clint_mtimecmp_gp: rd_data = mtimecmp_r;
      clint_mtime_gp:    rd_data = mtime_r;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_r     <= '0;
      // compare value parked at max so the timer stays quiet
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
      rsp_v_r     <= 1'b0;
    end
    else
    begin
      // mtime ticks on clk_i, a write overrides the increment
      if (wr && (off_i == clint_mtime_gp))
        mtime_r <= data_i;
      else
        mtime_r <= mtime_r + 1'b1;
      if (wr && (off_i == clint_mtimecmp_gp))
        mtimecmp_r <= data_i;
      if (wr && (off_i == clint_msip_gp))
        msip_r <= data_i[0];
      timer_irq_r <= (mtime_r >= mtimecmp_r);
      rsp_v_r     <= v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rsp_data_r <= (op_i == op_read) ? rd_data : '0;
    rsp_src_r  <= src_i;
  end

  assign rsp_v_o        = rsp_v_r;
  assign rsp_data_o     = rsp_data_r;
  assign rsp_src_o      = rsp_src_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

  // mtime itself reaching all ones is the only way past a maxed compare
  a_no_timer_at_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (&mtimecmp_r) && $past(&mtimecmp_r) && !$past(&mtime_r) |-> !timer_irq_o);

endmodule

// ==== hdl/cfg_slice.sv ====
`timescale 1ns/1ns

module cfg_slice
  #(
    parameter mem_msg_pkg::data_t core_id_p = 32'd0,
    parameter mem_msg_pkg::data_t boot_npc_p = 32'h8000_0000
  )
  (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    input  logic                   v_i,
    input  mem_msg_pkg::mem_op_e   op_i,
    input  tile_map_pkg::reg_off_t off_i,
    input  mem_msg_pkg::data_t     data_i,
    input  mem_msg_pkg::src_id_t   src_i,

    output logic                   rsp_v_o,
    output mem_msg_pkg::data_t     rsp_data_o,
    output mem_msg_pkg::src_id_t   rsp_src_o,

    output logic                   freeze_o,
    output mem_msg_pkg::data_t     boot_npc_o
  );

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  logic    freeze_r;
  data_t   npc_r;
  data_t   rd_data;
  logic    wr;

  logic    rsp_v_r;
  data_t   rsp_data_r;
  src_id_t rsp_src_r;

  assign wr = v_i && (op_i == op_write);

  always_comb
  begin
    case (off_i)
      cfg_freeze_gp:  rd_data = data_t'(freeze_r);
      cfg_npc_gp:     rd_data = npc_r;
      cfg_core_id_gp: rd_data = core_id_p;
      default:        rd_data = '0;
    endcase
  end

  // core comes out of reset frozen
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      freeze_r <= 1'b1;
      npc_r    <= boot_npc_p;
      rsp_v_r  <= 1'b0;
    end
    else
    begin
      if (wr && (off_i == cfg_freeze_gp))
        freeze_r <= data_i[0];
      if (wr && (off_i == cfg_npc_gp))
        npc_r <= data_i;
      rsp_v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rsp_data_r <= (op_i == op_read) ? rd_data : '0;
    rsp_src_r  <= src_i;
  end

  assign rsp_v_o    = rsp_v_r;
  assign rsp_data_o = rsp_data_r;
  assign rsp_src_o  = rsp_src_r;
  assign freeze_o   = freeze_r;
  assign boot_npc_o = npc_r;

  // one reply per strobe, exactly a cycle later
  a_rsp_follows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_v_o == $past(v_i));

endmodule

// ==== hdl/tile_map_pkg.sv ====
package tile_map_pkg;

  // device code sits in the top nibble of the 24-bit local address
  localparam int dev_code_lsb_gp = 20;
  localparam int dev_code_width_gp = 4;

  // register offset is the low half-word inside a device window
  localparam int reg_off_lsb_gp = 0;
  localparam int reg_off_width_gp = 16;

  typedef logic [dev_code_width_gp-1:0] dev_code_t;
  typedef logic [reg_off_width_gp-1:0] reg_off_t;

  // destination device after address decode
  // codes other than cfg and clint all land on the loopback
  typedef enum logic [dev_code_width_gp-1:0] {
    dev_loopback = 4'h0,
    dev_cfg      = 4'h2,
    dev_clint    = 4'h3
  } dev_e;

  // configuration slice registers
  localparam reg_off_t cfg_freeze_gp = 16'h0004;
  localparam reg_off_t cfg_npc_gp = 16'h0008;
  localparam reg_off_t cfg_core_id_gp = 16'h000c;

  // clint registers, same offsets as the usual risc-v clint
  localparam reg_off_t clint_msip_gp = 16'h0000;
  localparam reg_off_t clint_mtimecmp_gp = 16'h4000;
  localparam reg_off_t clint_mtime_gp = 16'hbff8;

endpackage

// ==== hdl/mem_msg_pkg.sv ====
package mem_msg_pkg;

  localparam int addr_width_gp = 24;
  localparam int data_width_gp = 32;

  // front-end and back-end request sources
  localparam int num_src_gp = 2;
  localparam int src_id_width_gp = $clog2(num_src_gp);

  typedef logic [addr_width_gp-1:0] addr_t;
  typedef logic [data_width_gp-1:0] data_t;
  typedef logic [src_id_width_gp-1:0] src_id_t;

  // single-beat memory opcodes
  // a write answers with zero data
  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

endpackage
